// ==== hw/mac_rx_macros.svh ====
// ----------------------------------------------------------
// mac rx constants
// widths, header length, crc-32 values and output stage count
// for the gigabit rgmii receive path
// ----------------------------------------------------------
`ifndef MAC_RX_MACROS_SVH
`define MAC_RX_MACROS_SVH

// ----------------------------------------------------------
// data path widths
// ----------------------------------------------------------

// one rgmii beat carries a full byte at 1g
`define MAC_RX_BYTE_W 8

// beat counter inside a frame, wide enough for jumbo frames
`define MAC_RX_CNT_W 16

// crc register width
`define MAC_RX_CRC_W 32

// ----------------------------------------------------------
// framing
// ----------------------------------------------------------

// seven preamble beats plus the sfd beat
`define MAC_RX_HDR_LEN 8

// ----------------------------------------------------------
// crc-32 (ieee 802.3, reflected form)
// ----------------------------------------------------------
`define MAC_RX_CRC_POLY 32'hEDB8_8320
`define MAC_RX_CRC_INIT 32'hFFFF_FFFF

// register value after data plus a correct fcs, not inverted
`define MAC_RX_CRC_RESIDUE 32'hDEBB_20E3

// ----------------------------------------------------------
// output retiming
// ----------------------------------------------------------
`define MAC_RX_OUT_STAGES 2

`endif

// ==== hw/mac_rx_pkg.sv ====
// ----------------------------------------------------------
// mac rx types
// beat, stream and link status structs plus state enums
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

package mac_rx_pkg;

    // ----------------------------------------------------------
    // captured rgmii beat
    // ----------------------------------------------------------

    // data from both clock edges, dv and err from rx_ctl
    typedef struct packed {
        logic [`MAC_RX_BYTE_W-1:0] data;
        logic                      dv;
        logic                      err;
    } rx_beat_t;

    // ----------------------------------------------------------
    // delivered byte stream
    // ----------------------------------------------------------

    // crc_good only means something together with eof
    typedef struct packed {
        logic [`MAC_RX_BYTE_W-1:0] data;
        logic                      valid;
        logic                      sof;
        logic                      eof;
        logic                      crc_good;
    } rx_stream_t;

    // ----------------------------------------------------------
    // in-band link status
    // ----------------------------------------------------------

    // speed code as sent by the phy in the gap nibble
    typedef enum logic [1:0] {
        speed_10m  = 2'b00,
        speed_100m = 2'b01,
        speed_1g   = 2'b10
    } link_speed_e;

    // member order follows the nibble: bit 3 down to bit 0
    typedef struct packed {
        logic        full_duplex;
        link_speed_e speed;
        logic        link_up;
    } link_status_t;

    // frame states of the receive sequencer
    typedef enum logic [1:0] {
        rx_idle,
        rx_header,
        rx_payload
    } rx_state_e;

endpackage

// ==== hw/rx_input_stage.sv ====
// ----------------------------------------------------------
// rx input stage
// registers the captured rgmii beat and picks up the
// in-band link status from the interframe gap
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

module rx_input_stage import mac_rx_pkg::*; (
    input  logic         mac_rx_clk,
    input  logic         arst_n_i,

    // beat from the ddr capture
    input  rx_beat_t     beat_i,

    // registered beat towards the frame sequencer
    output rx_beat_t     beat_o,

    // latched in-band status
    output link_status_t link_status_o
);

    rx_beat_t     beat_q;
    link_status_t link_status_q;
    logic         gap_beat;

    // ----------------------------------------------------------
    // beat register
    // ----------------------------------------------------------

    // captured beat, one cycle behind the pins
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_q <= '0;
        end else begin
            beat_q <= beat_i;
        end
    end

    // ----------------------------------------------------------
    // in-band status
    // ----------------------------------------------------------

    // rx_ctl low on both edges marks an idle gap beat
    assign gap_beat = !beat_q.dv && !beat_q.err;

    // low nibble of a gap beat is link, speed and duplex
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            link_status_q <= '0;
        end else if (gap_beat) begin
            link_status_q <= link_status_t'(beat_q.data[3:0]);
        end
    end

    assign beat_o        = beat_q;
    assign link_status_o = link_status_q;

    // status may only move after a beat without a carrier error
    a_status_no_err : assert property (
        @(posedge mac_rx_clk) disable iff (!arst_n_i)
        !$stable(link_status_q) |-> !$past(beat_q.err)
    );

endmodule

// ==== hw/rx_crc32_check.sv ====
// ----------------------------------------------------------
// rx crc-32 check
// byte-wide reflected crc-32 register, high output while the
// register holds the good-frame residue
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

module rx_crc32_check (
    input  logic                      mac_rx_clk,
    input  logic                      arst_n_i,

    // reload seed
    input  logic                      clear_i,

    // fold byte_i into the register
    input  logic                      en_i,
    input  logic [`MAC_RX_BYTE_W-1:0] byte_i,

    // register equals the residue
    output logic                      crc_ok_o
);

    logic [`MAC_RX_CRC_W-1:0] crc_q;
    logic [`MAC_RX_CRC_W-1:0] crc_next;

    // ----------------------------------------------------------
    // one byte, lsb first, through the reflected polynomial
    // ----------------------------------------------------------
    function automatic logic [`MAC_RX_CRC_W-1:0] crc_fold(
        input logic [`MAC_RX_CRC_W-1:0]  crc_in,
        input logic [`MAC_RX_BYTE_W-1:0] data_in
    );
        logic [`MAC_RX_CRC_W-1:0] c;
        c = crc_in ^ {{(`MAC_RX_CRC_W-`MAC_RX_BYTE_W){1'b0}}, data_in};
        for (int i = 0; i < `MAC_RX_BYTE_W; i++) begin
            // shift out bit 0, feed back the poly when it was set
            if (c[0]) begin
                c = (c >> 1) ^ `MAC_RX_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_fold(crc_q, byte_i);

    // ----------------------------------------------------------
    // crc register
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crc_q <= `MAC_RX_CRC_INIT;
        end else if (clear_i) begin
            crc_q <= `MAC_RX_CRC_INIT;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // data followed by its own fcs always leaves the same value
    assign crc_ok_o = (crc_q == `MAC_RX_CRC_RESIDUE);

    // the sequencer never seeds and folds in the same cycle
    a_clear_en_excl : assert property (
        @(posedge mac_rx_clk) disable iff (!arst_n_i)
        !(clear_i && en_i)
    );

endmodule

// ==== hw/rx_frame_ctrl.sv ====
// ----------------------------------------------------------
// rx frame control
// strips preamble and sfd by position, drives the crc checker
// and builds the byte stream with sof, eof and crc result
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

module rx_frame_ctrl import mac_rx_pkg::*; (
    input  logic                      mac_rx_clk,
    input  logic                      arst_n_i,

    // registered beat from the input stage
    input  rx_beat_t                  beat_i,

    // crc checker interface
    input  logic                      crc_ok_i,
    output logic                      crc_clear_o,
    output logic                      crc_en_o,
    output logic [`MAC_RX_BYTE_W-1:0] crc_byte_o,

    // delivered stream
    output rx_stream_t                stream_o
);

    // beat number of the sfd, the last header beat to drop
    localparam logic [`MAC_RX_CNT_W-1:0] HDR_LAST = `MAC_RX_CNT_W'(`MAC_RX_HDR_LEN - 1);

    rx_state_e                 state_q;
    logic [`MAC_RX_CNT_W-1:0]  beat_cnt_q;

    // one byte held back so the last one can carry eof
    logic [`MAC_RX_BYTE_W-1:0] pend_data_q;
    logic                      pend_valid_q;
    logic                      pend_sof_q;

    rx_stream_t                stream_q;

    // ----------------------------------------------------------
    // crc sequencing
    // ----------------------------------------------------------

    // seed during the header, fold every payload beat incl. fcs
    assign crc_clear_o = (state_q == rx_header);
    assign crc_en_o    = (state_q == rx_payload) && beat_i.dv;
    assign crc_byte_o  = beat_i.data;

    // ----------------------------------------------------------
    // frame state, beat counter and pending byte
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= rx_idle;
            beat_cnt_q   <= '0;
            pend_valid_q <= 1'b0;
            pend_sof_q   <= 1'b0;
        end else begin
            // beats counted only while the carrier is up
            if (!beat_i.dv) begin
                beat_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end

            case (state_q)
                rx_idle: begin
                    // first preamble beat
                    if (beat_i.dv) begin
                        state_q <= rx_header;
                    end
                end
                rx_header: begin
                    // runt ending inside the header emits nothing
                    if (!beat_i.dv) begin
                        state_q <= rx_idle;
                    end else if (beat_cnt_q == HDR_LAST) begin
                        state_q <= rx_payload;
                    end
                end
                rx_payload: begin
                    if (beat_i.dv) begin
                        pend_valid_q <= 1'b1;
                        pend_sof_q   <= !pend_valid_q;
                    end else begin
                        pend_valid_q <= 1'b0;
                        pend_sof_q   <= 1'b0;
                        state_q      <= rx_idle;
                    end
                end
                default: begin
                    state_q <= rx_idle;
                end
            endcase
        end
    end

    // payload byte waits here until the next beat shows whether it is the last
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_data_q <= '0;
        end else if (crc_en_o) begin
            pend_data_q <= beat_i.data;
        end
    end

    // ----------------------------------------------------------
    // stream register
    // ----------------------------------------------------------

    // pending byte goes out when the next beat arrives or dv drops
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stream_q <= '0;
        end else begin
            stream_q.data     <= pend_data_q;
            stream_q.valid    <= (state_q == rx_payload) && pend_valid_q;
            stream_q.sof      <= (state_q == rx_payload) && pend_valid_q && pend_sof_q;
            stream_q.eof      <= (state_q == rx_payload) && pend_valid_q && !beat_i.dv;
            // crc register already holds the last fcs byte here
            stream_q.crc_good <= (state_q == rx_payload) && pend_valid_q && !beat_i.dv
                                 && crc_ok_i;
        end
    end

    assign stream_o = stream_q;

    // strobes only ever ride on a valid byte
    a_eof_has_valid : assert property (
        @(posedge mac_rx_clk) disable iff (!arst_n_i)
        stream_q.eof |-> stream_q.valid
    );

    a_sof_has_valid : assert property (
        @(posedge mac_rx_clk) disable iff (!arst_n_i)
        stream_q.sof |-> stream_q.valid
    );

endmodule

// ==== hw/mac_rx.sv ====
// ----------------------------------------------------------
// mac rx top
// gigabit rgmii receiver: input stage, frame control and
// crc check, with retimed stream and status outputs
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

module mac_rx import mac_rx_pkg::*; (
    input  logic         mac_rx_clk,
    input  logic         arst_n_i,

    // one captured rgmii beat per clock
    input  rx_beat_t     rgmii_beat_i,

    // frame bytes and in-band status
    output rx_stream_t   rx_stream_o,
    output link_status_t link_status_o
);

    rx_beat_t                  beat_q;
    link_status_t              link_status_q;
    logic                      crc_clear;
    logic                      crc_en;
    logic [`MAC_RX_BYTE_W-1:0] crc_byte;
    logic                      crc_ok;
    rx_stream_t                stream;

    // status lags one cycle to line up with the stream path
    link_status_t              status_align_q;

    rx_stream_t                stream_pipe_q [`MAC_RX_OUT_STAGES];
    link_status_t              status_pipe_q [`MAC_RX_OUT_STAGES];

    // ----------------------------------------------------------
    // receive blocks
    // ----------------------------------------------------------
    rx_input_stage u_input_stage (
        .mac_rx_clk    (mac_rx_clk),
        .arst_n_i      (arst_n_i),
        .beat_i        (rgmii_beat_i),
        .beat_o        (beat_q),
        .link_status_o (link_status_q)
    );

    rx_frame_ctrl u_frame_ctrl (
        .mac_rx_clk  (mac_rx_clk),
        .arst_n_i    (arst_n_i),
        .beat_i      (beat_q),
        .crc_ok_i    (crc_ok),
        .crc_clear_o (crc_clear),
        .crc_en_o    (crc_en),
        .crc_byte_o  (crc_byte),
        .stream_o    (stream)
    );

    rx_crc32_check u_crc32_check (
        .mac_rx_clk (mac_rx_clk),
        .arst_n_i   (arst_n_i),
        .clear_i    (crc_clear),
        .en_i       (crc_en),
        .byte_i     (crc_byte),
        .crc_ok_o   (crc_ok)
    );

    // ----------------------------------------------------------
    // output retiming
    // ----------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_align_q <= '0;
            for (int i = 0; i < `MAC_RX_OUT_STAGES; i++) begin
                stream_pipe_q[i] <= '0;
                status_pipe_q[i] <= '0;
            end
        end else begin
            status_align_q   <= link_status_q;
            stream_pipe_q[0] <= stream;
            status_pipe_q[0] <= status_align_q;
            // plain shift through the remaining stages
            for (int i = 1; i < `MAC_RX_OUT_STAGES; i++) begin
                stream_pipe_q[i] <= stream_pipe_q[i-1];
                status_pipe_q[i] <= status_pipe_q[i-1];
            end
        end
    end

    assign rx_stream_o   = stream_pipe_q[`MAC_RX_OUT_STAGES-1];
    assign link_status_o = status_pipe_q[`MAC_RX_OUT_STAGES-1];

endmodule

// ==== test/mac_rx_tb_tasks.svh ====
// ----------------------------------------------------------
// mac rx testbench tasks
// frame builder, crc-32 reference model and directed tests
// ----------------------------------------------------------
`ifndef MAC_RX_TB_TASKS_SVH
`define MAC_RX_TB_TASKS_SVH

// ----------------------------------------------------------
// checks and bookkeeping
// ----------------------------------------------------------
task automatic check_value(input string sig, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
        $display("error at %0t: %s expected %0h got %0h", $time, sig, exp, got);
        errors++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
        $display("failure at %0t: %s", $time, what);
        errors++;
    end
endtask

task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, errors - err_before);
    end
endtask

// forget expected and captured frames
task automatic clear_capture();
    exp_q.delete();
    exp_len_q.delete();
    exp_good_q.delete();
    rx_q.delete();
    sof_idx_q.delete();
    eof_idx_q.delete();
    crc_good_q.delete();
    first_valid_cyc = -1;
    first_drive_cyc = -1;
endtask

// ----------------------------------------------------------
// stimulus
// ----------------------------------------------------------

// inputs change a little after the rising edge
task automatic drive_beat(input logic [7:0] data, input logic dv);
    @(posedge mac_rx_clk);
    #DRIVE_DELAY;
    rgmii_beat_i = '{data: data, dv: dv, err: 1'b0};
endtask

task automatic drive_idle(input int beats);
    repeat (beats) drive_beat(idle_data, 1'b0);
endtask

task automatic fill_payload(input int len);
    payload_q.delete();
    repeat (len) payload_q.push_back(8'($random(tb_seed)));
endtask

// bit-serial ieee crc-32, lsb of each byte first, result inverted
function automatic logic [31:0] crc32_ref();
    logic [31:0] crc;
    logic        fb;
    crc = `MAC_RX_CRC_INIT;
    foreach (payload_q[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ payload_q[i][b];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ `MAC_RX_CRC_POLY;
            end
        end
    end
    return ~crc;
endfunction

// payload plus fcs with the low byte first
// flip corrupts one payload bit once the fcs is known
task automatic build_frame(input logic flip);
    logic [31:0] fcs;
    fcs    = crc32_ref();
    wire_q = payload_q;
    for (int k = 0; k < FCS_LEN; k++) begin
        wire_q.push_back(fcs[8*k +: 8]);
    end
    if (flip) begin
        wire_q[20] = wire_q[20] ^ 8'h08;
    end
    foreach (wire_q[i]) begin
        exp_q.push_back(wire_q[i]);
    end
    exp_len_q.push_back(wire_q.size());
    exp_good_q.push_back(!flip);
endtask

// preamble and sfd, then the frame bytes with the carrier up
task automatic send_frame();
    repeat (`MAC_RX_HDR_LEN - 1) drive_beat(8'h55, 1'b1);
    drive_beat(8'hD5, 1'b1);
    foreach (wire_q[i]) begin
        drive_beat(wire_q[i], 1'b1);
        if (i == 0 && first_drive_cyc < 0) begin
            first_drive_cyc = cycle_cnt;
        end
    end
endtask

// ----------------------------------------------------------
// response handling
// ----------------------------------------------------------
task automatic wait_for_eofs(input int count);
    int waited;
    waited = 0;
    while (eof_idx_q.size() < count && waited < EOF_WAIT) begin
        @(negedge mac_rx_clk);
        waited++;
    end
    check_true(eof_idx_q.size() >= count, "end of frame strobe never arrived");
    // a few more cycles so stray bytes would show up
    repeat (4) @(negedge mac_rx_clk);
endtask

task automatic compare_capture();
    int start;
    check_value("received byte count", rx_q.size(), exp_q.size());
    for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
        check_value("rx_stream_o.data", rx_q[i], exp_q[i]);
    end
    check_value("sof count", sof_idx_q.size(), exp_len_q.size());
    check_value("eof count", eof_idx_q.size(), exp_len_q.size());
    start = 0;
    foreach (exp_len_q[k]) begin
        if (k < sof_idx_q.size()) begin
            check_value("sof position", sof_idx_q[k], start);
        end
        if (k < eof_idx_q.size()) begin
            check_value("eof position", eof_idx_q[k], start + exp_len_q[k] - 1);
            check_value("rx_stream_o.crc_good", crc_good_q[k], exp_good_q[k]);
        end
        start += exp_len_q[k];
    end
endtask

// ----------------------------------------------------------
// directed tests
// ----------------------------------------------------------
task automatic check_reset_outputs();
    int err_before;
    err_before = errors;
    repeat (TAIL_CYCLES) begin
        @(negedge mac_rx_clk);
        check_value("rx_stream_o.data", rx_stream_o.data, 8'h00);
        check_value("rx_stream_o.valid", rx_stream_o.valid, 1'b0);
        check_value("rx_stream_o.sof", rx_stream_o.sof, 1'b0);
        check_value("rx_stream_o.eof", rx_stream_o.eof, 1'b0);
        check_value("rx_stream_o.crc_good", rx_stream_o.crc_good, 1'b0);
        check_value("link_status_o", link_status_o, 4'h0);
    end
    finish_test("reset outputs", err_before);
endtask

task automatic deliver_good_frame();
    int err_before;
    err_before = errors;
    clear_capture();
    fill_payload(PAYLOAD_LEN);
    build_frame(1'b0);
    send_frame();
    drive_idle(1);
    wait_for_eofs(1);
    compare_capture();
    check_value("first byte latency", first_valid_cyc - first_drive_cyc, OUT_LATENCY);
    finish_test("good frame", err_before);
endtask

// same payload as the good frame, one bit flipped
task automatic detect_bad_crc();
    int err_before;
    err_before = errors;
    clear_capture();
    build_frame(1'b1);
    send_frame();
    drive_idle(1);
    wait_for_eofs(1);
    compare_capture();
    finish_test("bad crc frame", err_before);
endtask

task automatic track_link_status();
    int           err_before;
    int           start_cyc;
    int           waited;
    logic [3:0]   nib_list [STATUS_CASES];
    link_speed_e  exp_speed;
    link_status_t prev_status;
    err_before = errors;
    // up at each speed, half and full duplex
    nib_list = '{4'h1, 4'h3, 4'h5, 4'hD, 4'h9};
    foreach (nib_list[k]) begin
        prev_status = link_status_o;
        idle_data   = {4'h0, nib_list[k]};
        drive_idle(1);
        start_cyc = cycle_cnt;
        waited    = 0;
        // new code comes through the same retiming as a frame byte
        while (link_status_o == prev_status && waited < STATUS_HOLD) begin
            @(negedge mac_rx_clk);
            waited++;
        end
        check_value("link_status_o latency", cycle_cnt - start_cyc, OUT_LATENCY);
        case (nib_list[k][2:1])
            2'b00:   exp_speed = speed_10m;
            2'b01:   exp_speed = speed_100m;
            default: exp_speed = speed_1g;
        endcase
        check_value("link_status_o.link_up", link_status_o.link_up, nib_list[k][0]);
        check_value("link_status_o.speed", link_status_o.speed, exp_speed);
        check_value("link_status_o.full_duplex", link_status_o.full_duplex,
                    nib_list[k][3]);
    end
    finish_test("link status", err_before);
endtask

// two frames with a single gap beat between them
task automatic run_back_to_back();
    int err_before;
    err_before = errors;
    clear_capture();
    fill_payload(PAYLOAD_LEN);
    build_frame(1'b0);
    send_frame();
    drive_idle(1);
    fill_payload(PAYLOAD_LEN);
    build_frame(1'b0);
    send_frame();
    drive_idle(1);
    wait_for_eofs(2);
    compare_capture();
    finish_test("back-to-back frames", err_before);
endtask

// carrier drops inside the header
task automatic drop_runt();
    int err_before;
    err_before = errors;
    clear_capture();
    repeat (RUNT_BEATS) drive_beat(8'h55, 1'b1);
    drive_idle(1);
    repeat (TAIL_CYCLES) @(negedge mac_rx_clk);
    check_value("valid bytes after runt", rx_q.size(), 0);
    finish_test("runt frame", err_before);
endtask

`endif

// ==== test/tb_mac_rx.sv ====
// ----------------------------------------------------------
// mac rx testbench
// drives captured rgmii beats into the receiver and checks
// the delivered stream and the in-band link status
// ----------------------------------------------------------
`include "mac_rx_macros.svh"

module tb_mac_rx import mac_rx_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int DRIVE_DELAY   = 2;
    localparam int PAYLOAD_LEN   = 60;
    localparam int FCS_LEN       = 4;
    localparam int FRAME_BEATS   = `MAC_RX_HDR_LEN + PAYLOAD_LEN + FCS_LEN;
    localparam int TAIL_CYCLES   = 12;
    localparam int EOF_WAIT      = 16;
    localparam int STATUS_HOLD   = 8;
    localparam int STATUS_CASES  = 5;
    localparam int RUNT_BEATS    = 6;

    // cycles from driving a beat to seeing it on the outputs
    localparam int OUT_LATENCY   = 5;

    // ----------------------------------------------------------
    // run length budget
    // ----------------------------------------------------------

    // reset, reset check, good and bad frame, status, two frames, runt
    localparam int TEST_BEATS = RESET_CYCLES + TAIL_CYCLES
                              + 2 * (FRAME_BEATS + 1 + TAIL_CYCLES)
                              + STATUS_CASES * (STATUS_HOLD + 1)
                              + (2 * FRAME_BEATS + 2 + TAIL_CYCLES)
                              + (RUNT_BEATS + 1 + TAIL_CYCLES);
    localparam int TIMEOUT_LIMIT = TEST_BEATS + 200;

    logic         mac_rx_clk;
    logic         arst_n_i;
    rx_beat_t     rgmii_beat_i;
    rx_stream_t   rx_stream_o;
    link_status_t link_status_o;

    integer       tb_seed;
    int           cycle_cnt = 0;
    int           errors;
    int           tests_run;
    int           tests_failed;

    // low nibble of the gap data carries the status code
    logic [7:0]   idle_data;

    // frame under construction and what the stream should carry
    logic [7:0]   payload_q [$];
    logic [7:0]   wire_q [$];
    logic [7:0]   exp_q [$];
    int           exp_len_q [$];
    logic         exp_good_q [$];

    // monitor capture
    logic [7:0]   rx_q [$];
    int           sof_idx_q [$];
    int           eof_idx_q [$];
    logic         crc_good_q [$];
    int           first_valid_cyc;
    int           first_drive_cyc;

    mac_rx i_dut (
        .mac_rx_clk    (mac_rx_clk),
        .arst_n_i      (arst_n_i),
        .rgmii_beat_i  (rgmii_beat_i),
        .rx_stream_o   (rx_stream_o),
        .link_status_o (link_status_o)
    );

    initial begin
        mac_rx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) mac_rx_clk = ~mac_rx_clk;
    end

    // cycle counter doubles as the run watchdog
    always @(posedge mac_rx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // output monitor
    // ----------------------------------------------------------

    // sampled mid-cycle where the retimed outputs are settled
    always @(negedge mac_rx_clk) begin
        if (arst_n_i && rx_stream_o.valid) begin
            if (rx_q.size() == 0) begin
                first_valid_cyc = cycle_cnt;
            end
            if (rx_stream_o.sof) begin
                sof_idx_q.push_back(rx_q.size());
            end
            if (rx_stream_o.eof) begin
                eof_idx_q.push_back(rx_q.size());
                crc_good_q.push_back(rx_stream_o.crc_good);
            end
            rx_q.push_back(rx_stream_o.data);
        end
    end

`include "mac_rx_tb_tasks.svh"

    initial begin
        tb_seed      = 32'hd6c3_285b;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        idle_data    = 8'h00;
        arst_n_i     = 1'b0;
        rgmii_beat_i = '0;
        repeat (RESET_CYCLES) @(posedge mac_rx_clk);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;

        check_reset_outputs();
        deliver_good_frame();
        detect_bad_crc();
        track_link_status();
        run_back_to_back();
        drop_runt();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== mac_rx.f ====
+incdir+hw
+incdir+test
hw/mac_rx_pkg.sv
hw/rx_input_stage.sv
hw/rx_crc32_check.sv
hw/rx_frame_ctrl.sv
hw/mac_rx.sv
test/tb_mac_rx.sv

// ==== Makefile ====
# Verilator flow for the mac rx receiver
# any variable can be overridden, e.g. make sim SIM_LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= mac_rx.f
RTL_TOP    ?= mac_rx
TB_TOP     ?= tb_mac_rx
OBJ_DIR    ?= obj_dir
SIM_LOG    ?= sim.log
PASS_TEXT  ?= TEST PASS
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
SIM_EXE    ?= V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

# rtl top only, the testbench is parsed but not elaborated
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_EXE)
	./$(OBJ_DIR)/$(SIM_EXE) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -q "$(PASS_TEXT)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
